// File: source/fetch_pkg.sv
`default_nettype none

// core side geometry and encodings for the fetch path
package fetch_pkg;

  localparam int XLEN        = 32;  // address and instruction width
  localparam int LINE_WORDS  = 4;   // words per cache line
  localparam int OFFSET_BITS = 2;   // word select inside a line
  localparam int INDEX_BITS  = 4;   // 16 lines

  // tag is whatever is left above index, offset and the two byte bits
  localparam int TAG_BITS = XLEN - INDEX_BITS - OFFSET_BITS - 2;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;  // first fetch address
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0 bubble

endpackage

`default_nettype wire

// File: source/bus_pkg.sv
`default_nettype none

// wishbone side widths and ram sizing
package bus_pkg;

  localparam int BUS_DW = 32;  // data width
  localparam int BUS_AW = 32;  // byte address width

  // default depth in words, power of two so the index wraps cleanly
  localparam int RAM_WORDS_DEFAULT = 1024;

endpackage

`default_nettype wire

// File: source/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        redirect_i,     // from a later stage
  input  wire  [fetch_pkg::XLEN-1:0] redirect_pc_i,
  input  wire                        stall_i,
  input  wire                        hit_i,          // cache has fetch_pc_o
  input  wire  [fetch_pkg::XLEN-1:0] hit_word_i,
  output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
  output logic [fetch_pkg::XLEN-1:0] inst_o,
  output logic [fetch_pkg::XLEN-1:0] inst_pc_o,
  output logic                       inst_valid_o
);

  import fetch_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] inst_q;     // raw word, shown only while valid
  logic [XLEN-1:0] inst_pc_q;
  logic            valid_q;
  logic            take_hit;   // hit that actually advances

  assign take_hit = !redirect_i && !stall_i && hit_i;

  // priority redirect, stall, hit, miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end else if (redirect_i) begin
      pc_q    <= redirect_pc_i;
      valid_q <= 1'b0;          // old word is dropped
    end else if (stall_i) begin
      pc_q    <= pc_q;          // hold everything
      valid_q <= valid_q;
    end else if (hit_i) begin
      pc_q    <= pc_q + 32'd4;
      valid_q <= 1'b1;
    end else begin
      valid_q <= 1'b0;          // waiting on refill
    end
  end

  // fetch register payload
  always_ff @(posedge clk) begin
    if (take_hit) begin
      inst_q    <= hit_word_i;
      inst_pc_q <= pc_q;
    end
  end

  assign fetch_pc_o   = pc_q;
  assign inst_pc_o    = inst_pc_q;
  assign inst_valid_o = valid_q;
  assign inst_o       = valid_q ? inst_q : NOP_INST;  // bubble when nothing valid

endmodule

`default_nettype wire

// File: source/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        flush_i,        // drops every line at once
  input  wire  [fetch_pkg::XLEN-1:0] fetch_pc_i,
  input  wire                        refill_ack_i,
  input  wire  [fetch_pkg::XLEN-1:0] refill_data_i,
  output logic                       hit_o,
  output logic [fetch_pkg::XLEN-1:0] hit_word_o,
  output logic                       refill_req_o,
  output logic [fetch_pkg::XLEN-1:0] refill_addr_o   // byte address of the word
);

  import fetch_pkg::*;

  // pc split
  logic [TAG_BITS-1:0]    pc_tag;
  logic [INDEX_BITS-1:0]  pc_idx;
  logic [OFFSET_BITS-1:0] pc_off;

  // line storage
  logic [XLEN-1:0]          data_q [2**INDEX_BITS][LINE_WORDS];
  logic [TAG_BITS-1:0]      tag_q  [2**INDEX_BITS];
  logic [2**INDEX_BITS-1:0] valid_q;

  // refill fsm, idle when busy_q is low
  logic                   busy_q;
  logic                   stale_q;     // flush seen while refilling
  logic [TAG_BITS-1:0]    ref_tag_q;
  logic [INDEX_BITS-1:0]  ref_idx_q;
  logic [OFFSET_BITS-1:0] ref_cnt_q;   // word being fetched, in order
  logic                   start_refill;
  logic                   last_word;

  assign {pc_tag, pc_idx, pc_off} = fetch_pc_i[XLEN-1:2];  // byte bits ignored

  assign hit_o      = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_word_o = data_q[pc_idx][pc_off];

  assign start_refill = !busy_q && !hit_o;
  assign last_word    = busy_q && refill_ack_i &&
                        (ref_cnt_q == OFFSET_BITS'(LINE_WORDS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      stale_q   <= 1'b0;
      ref_cnt_q <= '0;
    end else if (start_refill) begin
      busy_q    <= 1'b1;
      stale_q   <= 1'b0;         // a flush right now predates the data
      ref_cnt_q <= '0;
    end else if (busy_q) begin
      if (flush_i)
        stale_q <= 1'b1;         // words may predate the flush
      if (refill_ack_i) begin
        ref_cnt_q <= ref_cnt_q + 1'b1;
        if (last_word)
          busy_q <= 1'b0;
      end
    end
  end

  // which line is being refilled
  always_ff @(posedge clk) begin
    if (start_refill) begin
      ref_tag_q <= pc_tag;
      ref_idx_q <= pc_idx;
    end
  end

  // valid bits, flush wins over everything
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      valid_q <= '0;
    else if (flush_i)
      valid_q <= '0;
    else if (start_refill)
      valid_q[pc_idx] <= 1'b0;   // victim line is overwritten word by word
    else if (last_word)
      valid_q[ref_idx_q] <= !stale_q;
  end

  always_ff @(posedge clk) begin
    if (busy_q && refill_ack_i)
      data_q[ref_idx_q][ref_cnt_q] <= refill_data_i;
    if (last_word)
      tag_q[ref_idx_q] <= ref_tag_q;  // tag written with the final word
  end

  assign refill_req_o  = busy_q;      // held until each ack
  assign refill_addr_o = {ref_tag_q, ref_idx_q, ref_cnt_q, 2'b00};

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          dreq_i,          // held until dack_o
  input  wire                          dwe_i,
  input  wire  [bus_pkg::BUS_AW-1:0]   daddr_i,
  input  wire  [bus_pkg::BUS_DW-1:0]   dwdata_i,
  input  wire                          refill_req_i,    // held until refill_ack_o
  input  wire  [bus_pkg::BUS_AW-1:0]   refill_addr_i,
  input  wire  [bus_pkg::BUS_DW-1:0]   wb_dat_r_i,
  input  wire                          wb_ack_i,
  output logic [bus_pkg::BUS_DW-1:0]   drdata_o,
  output logic                         dack_o,
  output logic                         refill_ack_o,
  output logic [bus_pkg::BUS_DW-1:0]   refill_data_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         wb_we_o,
  output logic [bus_pkg::BUS_AW-1:0]   wb_adr_o,
  output logic [bus_pkg::BUS_DW-1:0]   wb_dat_w_o
);

  import bus_pkg::*;

  // owner state, both low means idle
  logic own_data_q;
  logic own_refill_q;
  logic idle;
  logic grant_data;
  logic grant_refill;

  assign idle         = !own_data_q && !own_refill_q;
  assign grant_data   = idle && dreq_i;                  // data port first
  assign grant_refill = idle && !dreq_i && refill_req_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      own_data_q   <= 1'b0;
      own_refill_q <= 1'b0;
      wb_we_o      <= 1'b0;
    end else if (grant_data) begin
      own_data_q <= 1'b1;
      wb_we_o    <= dwe_i;
    end else if (grant_refill) begin
      own_refill_q <= 1'b1;
      wb_we_o      <= 1'b0;      // refills only read
    end else if (wb_ack_i) begin
      // cycle ends where ack is sampled, one idle cycle follows
      own_data_q   <= 1'b0;
      own_refill_q <= 1'b0;
    end
  end

  // address and write data stay put for the whole cycle
  always_ff @(posedge clk) begin
    if (grant_data) begin
      wb_adr_o   <= daddr_i;
      wb_dat_w_o <= dwdata_i;
    end else if (grant_refill) begin
      wb_adr_o <= refill_addr_i;
    end
  end

  assign wb_cyc_o = !idle;
  assign wb_stb_o = !idle;       // classic, no waits between cyc and stb

  // responses only go to whoever owns the bus
  assign dack_o        = own_data_q && wb_ack_i;
  assign drdata_o      = own_data_q ? wb_dat_r_i : '0;
  assign refill_ack_o  = own_refill_q && wb_ack_i;
  assign refill_data_o = own_refill_q ? wb_dat_r_i : '0;

endmodule

`default_nettype wire

// File: source/wb_ram.sv
`timescale 1ns/1ns
`default_nettype none

module wb_ram #(
  parameter int RAM_WORDS = bus_pkg::RAM_WORDS_DEFAULT  // depth, power of two
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          wb_cyc_i,
  input  wire                          wb_stb_i,
  input  wire                          wb_we_i,
  input  wire  [bus_pkg::BUS_AW-1:0]   wb_adr_i,
  input  wire  [bus_pkg::BUS_DW-1:0]   wb_dat_w_i,
  output logic [bus_pkg::BUS_DW-1:0]   wb_dat_r_o,
  output logic                         wb_ack_o
);

  import bus_pkg::*;

  logic [BUS_DW-1:0]            mem_q [RAM_WORDS];
  logic [$clog2(RAM_WORDS)-1:0] word_idx;
  logic                         new_req;   // stb not yet answered

  // upper address bits dropped, so accesses wrap modulo the depth
  assign word_idx = wb_adr_i[$clog2(RAM_WORDS)+1:2];
  assign new_req  = wb_cyc_i && wb_stb_i && !wb_ack_o;

  // single cycle ack pulse per request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= new_req;
  end

  always_ff @(posedge clk) begin
    if (new_req && wb_we_i)
      mem_q[word_idx] <= wb_dat_w_i;
    if (new_req)
      wb_dat_r_o <= mem_q[word_idx];  // lines up with ack
  end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
  parameter int RAM_WORDS = bus_pkg::RAM_WORDS_DEFAULT
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          redirect_i,
  input  wire  [fetch_pkg::XLEN-1:0]   redirect_pc_i,
  input  wire                          stall_i,
  input  wire                          flush_i,
  input  wire                          dreq_i,
  input  wire                          dwe_i,
  input  wire  [bus_pkg::BUS_AW-1:0]   daddr_i,
  input  wire  [bus_pkg::BUS_DW-1:0]   dwdata_i,
  output wire  [fetch_pkg::XLEN-1:0]   inst_o,
  output wire  [fetch_pkg::XLEN-1:0]   inst_pc_o,
  output wire                          inst_valid_o,
  output wire  [bus_pkg::BUS_DW-1:0]   drdata_o,
  output wire                          dack_o
);

  import fetch_pkg::*;
  import bus_pkg::*;

  // fetch to cache
  wire [XLEN-1:0]   fetch_pc;
  wire              hit;
  wire [XLEN-1:0]   hit_word;
  // cache to arbiter
  wire              refill_req;
  wire [XLEN-1:0]   refill_addr;
  wire              refill_ack;
  wire [BUS_DW-1:0] refill_data;
  // wishbone
  wire              wb_cyc;
  wire              wb_stb;
  wire              wb_we;
  wire [BUS_AW-1:0] wb_adr;
  wire [BUS_DW-1:0] wb_dat_w;
  wire [BUS_DW-1:0] wb_dat_r;
  wire              wb_ack;

  fetch_ctrl u_fetch_ctrl (
    .clk(clk), .rst_n(rst_n),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i), .stall_i(stall_i),
    .hit_i(hit), .hit_word_i(hit_word),
    .fetch_pc_o(fetch_pc), .inst_o(inst_o), .inst_pc_o(inst_pc_o),
    .inst_valid_o(inst_valid_o)
  );

  icache u_icache (
    .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .fetch_pc_i(fetch_pc),
    .refill_ack_i(refill_ack), .refill_data_i(refill_data),
    .hit_o(hit), .hit_word_o(hit_word),
    .refill_req_o(refill_req), .refill_addr_o(refill_addr)
  );

  bus_arbiter u_bus_arbiter (
    .clk(clk), .rst_n(rst_n),
    .dreq_i(dreq_i), .dwe_i(dwe_i), .daddr_i(daddr_i), .dwdata_i(dwdata_i),
    .refill_req_i(refill_req), .refill_addr_i(refill_addr),
    .wb_dat_r_i(wb_dat_r), .wb_ack_i(wb_ack),
    .drdata_o(drdata_o), .dack_o(dack_o),
    .refill_ack_o(refill_ack), .refill_data_o(refill_data),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we),
    .wb_adr_o(wb_adr), .wb_dat_w_o(wb_dat_w)
  );

  wb_ram #(.RAM_WORDS(RAM_WORDS)) u_wb_ram (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_w_i(wb_dat_w),
    .wb_dat_r_o(wb_dat_r), .wb_ack_o(wb_ack)
  );

endmodule

`default_nettype wire

// File: testbench/bus_arbiter_assert.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter_assert (
  input wire                        clk,
  input wire                        rst_n,
  input wire                        wb_cyc_i,
  input wire                        wb_stb_i,
  input wire                        wb_we_i,
  input wire  [bus_pkg::BUS_AW-1:0] wb_adr_i,
  input wire  [bus_pkg::BUS_DW-1:0] wb_dat_w_i,
  input wire                        wb_ack_i
);

  int unsigned fail_cnt = 0;

  stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb_i |-> wb_cyc_i)
    else begin
      $error("stb raised outside a bus cycle");
      fail_cnt++;
    end

  // classic master keeps the request steady while waiting
  hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i) && $stable(wb_we_i)
                              && $stable(wb_dat_w_i))
    else begin
      $error("request changed or dropped before ack");
      fail_cnt++;
    end

  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_i |-> wb_stb_i)
    else begin
      $error("ack arrived with no stb");
      fail_cnt++;
    end

  drop_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_i |=> !wb_stb_i)  // one idle cycle after every transfer
    else begin
      $error("stb still high after ack");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: testbench/tb_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top;

  import fetch_pkg::*;
  import bus_pkg::*;

  localparam int          PROG_WORDS    = 64;   // ram depth, the whole program
  localparam int          PROG_AW       = 6;    // word index bits
  localparam logic [31:0] SEED          = 32'h4da7_8c31;
  localparam int          FETCH_TIMEOUT = 3000; // cycles
  localparam int          BUS_TIMEOUT   = 64;

  logic              clk;
  logic              rst_n;
  logic              redirect_i;
  logic [XLEN-1:0]   redirect_pc_i;
  logic              stall_i;
  logic              flush_i;
  logic              dreq_i;
  logic              dwe_i;
  logic [BUS_AW-1:0] daddr_i;
  logic [BUS_DW-1:0] dwdata_i;
  logic [XLEN-1:0]   inst_o;
  logic [XLEN-1:0]   inst_pc_o;
  logic              inst_valid_o;
  logic [BUS_DW-1:0] drdata_o;
  logic              dack_o;

  logic [31:0] ref_mem [PROG_WORDS];  // expected ram contents
  logic [31:0] lfsr_q;
  int          err_count;
  int          err_mark;              // errors at the end of the last test
  int          check_count;
  int          bubble_count;

  // compare process state
  logic [XLEN-1:0] exp_pc;            // next pc the stream must show
  logic [XLEN-1:0] held_inst;
  logic [XLEN-1:0] held_pc;
  logic            held_valid;
  logic            prev_hold;         // last edge was a stall without redirect
  logic            prev_redirect;

  fetch_top #(.RAM_WORDS(PROG_WORDS)) fetch_top_i (
    .clk(clk), .rst_n(rst_n),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .stall_i(stall_i), .flush_i(flush_i),
    .dreq_i(dreq_i), .dwe_i(dwe_i), .daddr_i(daddr_i), .dwdata_i(dwdata_i),
    .inst_o(inst_o), .inst_pc_o(inst_pc_o), .inst_valid_o(inst_valid_o),
    .drdata_o(drdata_o), .dack_o(dack_o)
  );

  bind bus_arbiter bus_arbiter_assert u_arb_assert (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o), .wb_we_i(wb_we_o),
    .wb_adr_i(wb_adr_o), .wb_dat_w_i(wb_dat_w_o), .wb_ack_i(wb_ack_i)
  );

  always #5 clk = ~clk;

  // galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};  // one step per bit
    end
    return v;
  endfunction

  // ram wraps modulo its depth
  function automatic logic [31:0] ref_fetch(input logic [31:0] pc);
    return ref_mem[pc[PROG_AW+1:2]];
  endfunction

  function automatic int total_errors();
    return err_count + fetch_top_i.u_bus_arbiter.u_arb_assert.fail_cnt;
  endfunction

  task automatic note_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic end_run;
    int total;
    total = total_errors();
    $display("checks %0d, bubbles %0d, errors %0d", check_count, bubble_count, total);
    if (total == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at %0t: %s", $time, what);
    err_count++;
    end_run();
  endtask

  task automatic test_done(input string name);
    int errs;
    @(negedge clk);  // counters settle away from the rising edge
    errs     = total_errors() - err_mark;
    err_mark = total_errors();
    $display("test %s: %0d errors", name, errs);
  endtask

  // one data port transfer, request held until dack
  task automatic data_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    bit acked;
    acked = 1'b0;
    rdata = '0;
    @(posedge clk);
    dreq_i   <= 1'b1;
    dwe_i    <= we;
    daddr_i  <= addr;
    dwdata_i <= wdata;
    for (int n = 0; n < BUS_TIMEOUT && !acked; n++) begin
      @(posedge clk);
      if (dack_o) begin
        acked  = 1'b1;
        rdata  = drdata_o;    // valid with dack
        dreq_i <= 1'b0;
      end
    end
    if (!acked)
      timeout_abort($sformatf("no dack for address %h", addr));
  endtask

  task automatic redirect_to(input logic [31:0] target);
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    @(posedge clk);
    redirect_i    <= 1'b0;
  endtask

  task automatic wait_for_pc(input logic [31:0] pc, input int limit);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(posedge clk);
      seen = inst_valid_o && (inst_pc_o == pc);
    end
    if (!seen)
      timeout_abort($sformatf("fetch never reached pc %h", pc));
  endtask

  // every cycle, outputs sampled at the edge
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc = RESET_PC;
    end else begin
      if (prev_hold) begin
        assert (inst_valid_o === held_valid && inst_o === held_inst && inst_pc_o === held_pc)
          else note_error("fetch output moved during a stall");
      end else if (inst_valid_o) begin
        check_count++;
        assert (inst_pc_o === exp_pc)
          else note_error($sformatf("pc %h, expected %h", inst_pc_o, exp_pc));
        assert (inst_o === ref_fetch(inst_pc_o))
          else note_error($sformatf("inst %h at pc %h, expected %h",
                                    inst_o, inst_pc_o, ref_fetch(inst_pc_o)));
        exp_pc = inst_pc_o + 32'd4;  // sequential unless redirected
      end
      if (prev_redirect)
        assert (!inst_valid_o) else note_error("instruction valid right after a redirect");
      if (!inst_valid_o) begin
        bubble_count++;
        assert (inst_o === NOP_INST)
          else note_error($sformatf("bubble shows %h instead of nop", inst_o));
      end
      if (redirect_i)
        exp_pc = redirect_pc_i;
    end
    prev_hold     = rst_n && stall_i && !redirect_i;  // redirect beats stall
    prev_redirect = rst_n && redirect_i;
    held_valid    = inst_valid_o;
    held_inst     = inst_o;
    held_pc       = inst_pc_o;
  end

  task automatic load_program;
    logic [31:0] word;
    logic [31:0] unused;
    for (int i = 0; i < PROG_WORDS; i++) begin
      word       = rand_bits(32);
      ref_mem[i] = word;
      data_access(1'b1, 32'(i * 4), word, unused);
    end
    // line 0 was filled from the empty ram while stalled
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    stall_i <= 1'b0;
    wait_for_pc(32'h180, FETCH_TIMEOUT);  // past the ram end, wraps
    test_done("1 program fetch");
  endtask

  task automatic random_redirects;
    logic [31:0] target;
    for (int k = 0; k < 4; k++) begin
      target = rand_bits(10) << 2;
      redirect_to(target);
      wait_for_pc(target, FETCH_TIMEOUT);
    end
    test_done("2 redirects");
  endtask

  task automatic random_stalls;
    int gap;
    int span;
    for (int k = 0; k < 8; k++) begin
      gap  = rand_bits(3);
      span = rand_bits(2) + 1;
      repeat (gap + 1) @(posedge clk);
      stall_i <= 1'b1;
      repeat (span) @(posedge clk);
      stall_i <= 1'b0;
    end
    test_done("3 stalls");
  endtask

  task automatic data_reads_under_refill;
    logic [31:0] addr;
    logic [31:0] got;
    bit          pending;
    for (int k = 0; k < 8; k++) begin
      pending = 1'b0;
      for (int n = 0; n < BUS_TIMEOUT && !pending; n++) begin
        @(posedge clk);
        pending = fetch_top_i.refill_req;
      end
      if (!pending)
        timeout_abort("no refill request showed up");
      addr = rand_bits(PROG_AW) << 2;
      data_access(1'b0, addr, '0, got);
      assert (got === ref_fetch(addr))
        else note_error($sformatf("read %h gave %h, expected %h", addr, got, ref_fetch(addr)));
    end
    test_done("4 data reads");
  endtask

  task automatic overwrite_and_flush;
    logic [31:0] base;
    logic [31:0] word;
    logic [31:0] unused;
    base = rand_bits(3) << 5;             // two cache lines
    redirect_to(base);
    wait_for_pc(base + 32'd28, FETCH_TIMEOUT);  // region now cached
    @(posedge clk);
    stall_i <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      word = rand_bits(32);
      ref_mem[base[PROG_AW+1:2] + i] = word;
      data_access(1'b1, base + 32'(4 * i), word, unused);
    end
    @(posedge clk);
    flush_i       <= 1'b1;
    redirect_i    <= 1'b1;
    redirect_pc_i <= base;
    @(posedge clk);
    flush_i    <= 1'b0;
    redirect_i <= 1'b0;
    stall_i    <= 1'b0;
    wait_for_pc(base + 32'd28, FETCH_TIMEOUT);
    test_done("5 overwrite and flush");
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b1;  // fetch frozen until the program is in
    flush_i       = 1'b0;
    dreq_i        = 1'b0;
    dwe_i         = 1'b0;
    daddr_i       = '0;
    dwdata_i      = '0;
    lfsr_q        = SEED;
    err_count     = 0;
    err_mark      = 0;
    check_count   = 0;
    bubble_count  = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    load_program();
    random_redirects();
    random_stalls();
    data_reads_under_refill();
    overwrite_and_flush();
    assert (bubble_count > 0) else note_error("no bubble cycle was ever seen");
    test_done("6 nop while not valid");
    end_run();
  end

endmodule

`default_nettype wire

// File: project.f
source/fetch_pkg.sv
source/bus_pkg.sv
source/fetch_ctrl.sv
source/icache.sv
source/bus_arbiter.sv
source/wb_ram.sv
source/fetch_top.sv
testbench/bus_arbiter_assert.sv
testbench/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  # packages first, then the rtl bottom up
  - source/fetch_pkg.sv
  - source/bus_pkg.sv
  - source/fetch_ctrl.sv
  - source/icache.sv
  - source/bus_arbiter.sv
  - source/wb_ram.sv
  - source/fetch_top.sv
  - target: test
    files:
      - testbench/bus_arbiter_assert.sv
      - testbench/tb_fetch_top.sv
